/* common/stopwatch_pkg.sv */
package stopwatch_pkg;

    //////////////////////////////////////////////////
    // Time representation
    //////////////////////////////////////////////////

    // Binary count of centiseconds, 19 bits covers 359999
    typedef logic [18:0] time_t;

    localparam time_t MAX_TIME    = 19'd359999;  // 59:59.99
    localparam time_t STEP_MINUTE = 19'd6000;    // One minute in centiseconds
    localparam time_t STEP_SECOND = 19'd100;     // One second in centiseconds

    //////////////////////////////////////////////////
    // Mode FSM states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_PROG         = 3'd0,  // Building the countdown time
        ST_UP_READY     = 3'd1,
        ST_UP_RUN       = 3'd2,
        ST_UP_HOLD      = 3'd3,
        ST_DOWN_READY   = 3'd4,  // Preset loaded, waiting for start
        ST_DOWN_RUN     = 3'd5,
        ST_DOWN_HOLD    = 3'd6,
        ST_DOWN_EXPIRED = 3'd7   // Reached zero, parked until clear
    } sw_state_t;

    //////////////////////////////////////////////////
    // Inter-stage bundles
    //////////////////////////////////////////////////

    // Conditioned front panel
    typedef struct packed {
        logic start_stop;  // Pulse
        logic clear;       // Pulse
        logic inc;         // Pulse
        logic prog_sw;     // Level
        logic up_sw;       // Level
        logic min_sw;      // Level
    } panel_t;

    // Mode FSM to time counter
    typedef struct packed {
        logic run;        // Count on each centisecond tick
        logic dir_up;     // 1 counts up, 0 counts down
        logic hold_zero;  // Force and keep zero
        logic clear;      // One-cycle strobe
        logic load;       // One-cycle strobe, copies preset
    } count_cmd_t;

    // Mode FSM to preset store, all one-cycle strobes
    typedef struct packed {
        logic add_min;
        logic add_sec;
        logic clear;
    } prog_cmd_t;

endpackage

/* control/mode_fsm.sv */
`timescale 1ns/1ps

module mode_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  stopwatch_pkg::panel_t      panel,
    input  logic                       at_zero,
    output stopwatch_pkg::sw_state_t   state,
    output stopwatch_pkg::count_cmd_t  count_cmd,
    output stopwatch_pkg::prog_cmd_t   prog_cmd
);

    stopwatch_pkg::sw_state_t  next_state;
    stopwatch_pkg::count_cmd_t count_next;
    stopwatch_pkg::prog_cmd_t  prog_next;
    logic                      in_up;
    logic                      in_down;
    logic                      prog_busy;

    assign in_up = (state == stopwatch_pkg::ST_UP_READY) ||
                   (state == stopwatch_pkg::ST_UP_RUN) ||
                   (state == stopwatch_pkg::ST_UP_HOLD);
    assign in_down = (state == stopwatch_pkg::ST_DOWN_READY) ||
                     (state == stopwatch_pkg::ST_DOWN_RUN) ||
                     (state == stopwatch_pkg::ST_DOWN_HOLD) ||
                     (state == stopwatch_pkg::ST_DOWN_EXPIRED);

    // Preset changes on the cycle after a programming strobe
    assign prog_busy = prog_cmd.add_min | prog_cmd.add_sec | prog_cmd.clear;

    //////////////////////////////////////////////////
    // Next state and command decode
    //////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        count_next = '0;
        prog_next  = '0;

        if (panel.prog_sw) begin                     // Program switch wins
            next_state = stopwatch_pkg::ST_PROG;
            if (state != stopwatch_pkg::ST_PROG) begin
                count_next.load = 1'b1;              // Show the preset
            end else begin
                if (panel.clear) begin
                    prog_next.clear = 1'b1;
                end else if (panel.inc) begin
                    prog_next.add_min = panel.min_sw;
                    prog_next.add_sec = ~panel.min_sw;
                end
                // Reload the display once the preset has settled
                count_next.load = prog_busy;
            end
        end else if (panel.up_sw) begin
            if (!in_up || panel.clear) begin
                next_state       = stopwatch_pkg::ST_UP_READY;
                count_next.clear = 1'b1;
            end else if (panel.start_stop) begin
                if (state == stopwatch_pkg::ST_UP_RUN) begin
                    next_state = stopwatch_pkg::ST_UP_HOLD;
                end else begin
                    next_state = stopwatch_pkg::ST_UP_RUN;
                end
            end
        end else begin
            // Ready in the down group means the preset is in the counter
            if (!in_down || panel.clear) begin
                next_state      = stopwatch_pkg::ST_DOWN_READY;
                count_next.load = 1'b1;
            end else if (state == stopwatch_pkg::ST_DOWN_RUN && at_zero) begin
                next_state = stopwatch_pkg::ST_DOWN_EXPIRED;
            end else if (panel.start_stop) begin
                case (state)
                    stopwatch_pkg::ST_DOWN_READY: next_state = stopwatch_pkg::ST_DOWN_RUN;
                    stopwatch_pkg::ST_DOWN_HOLD:  next_state = stopwatch_pkg::ST_DOWN_RUN;
                    stopwatch_pkg::ST_DOWN_RUN:   next_state = stopwatch_pkg::ST_DOWN_HOLD;
                    default:                      next_state = state;  // Expired ignores it
                endcase
            end
        end

        // Levels follow the state being entered
        count_next.run = (next_state == stopwatch_pkg::ST_UP_RUN) ||
                         (next_state == stopwatch_pkg::ST_DOWN_RUN);
        count_next.dir_up = (next_state == stopwatch_pkg::ST_UP_READY) ||
                            (next_state == stopwatch_pkg::ST_UP_RUN) ||
                            (next_state == stopwatch_pkg::ST_UP_HOLD);
        count_next.hold_zero = (next_state == stopwatch_pkg::ST_DOWN_EXPIRED);
    end

    //////////////////////////////////////////////////
    // State and command registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= stopwatch_pkg::ST_UP_READY;
            count_cmd <= '0;
            prog_cmd  <= '0;
        end else begin
            state     <= next_state;
            count_cmd <= count_next;
            prog_cmd  <= prog_next;
        end
    end

endmodule

/* control/preset_store.sv */
`timescale 1ns/1ps

module preset_store (
    input  logic                      clk,
    input  logic                      rst_n,
    input  stopwatch_pkg::prog_cmd_t  prog_cmd,
    output stopwatch_pkg::time_t      preset
);

    stopwatch_pkg::time_t step;
    stopwatch_pkg::time_t sum;  // 19 bits never wraps, MAX_TIME plus a minute fits

    // Pick the increment for this strobe
    always_comb begin
        if (prog_cmd.add_min) begin
            step = stopwatch_pkg::STEP_MINUTE;
        end else if (prog_cmd.add_sec) begin
            step = stopwatch_pkg::STEP_SECOND;
        end else begin
            step = '0;
        end
    end

    assign sum = preset + step;

    //////////////////////////////////////////////////
    // Programmed time register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            preset <= '0;
        end else if (prog_cmd.clear) begin
            preset <= '0;
        end else if (prog_cmd.add_min || prog_cmd.add_sec) begin
            // Saturate at 59:59.99
            if (sum > stopwatch_pkg::MAX_TIME) begin
                preset <= stopwatch_pkg::MAX_TIME;
            end else begin
                preset <= sum;
            end
        end
    end

endmodule

/* design/cs_tick_gen.sv */
`timescale 1ns/1ps

module cs_tick_gen #(
    parameter int TICKS_PER_CS = 100000
) (
    input  logic clk,
    input  logic rst_n,
    output logic cs_tick
);

    // A single-cycle period still needs a one-bit counter
    localparam int CNT_W = (TICKS_PER_CS > 1) ? $clog2(TICKS_PER_CS) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             wrap;

    assign wrap = (div_cnt == CNT_W'(TICKS_PER_CS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            cs_tick <= 1'b0;
        end else begin
            cs_tick <= wrap;  // One pulse per wrap
            if (wrap) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/input_sync.sv */
`timescale 1ns/1ps

module input_sync (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_stop_btn,
    input  logic                   clear_btn,
    input  logic                   inc_btn,
    input  logic                   prog_sw,
    input  logic                   up_sw,
    input  logic                   min_sw,
    output stopwatch_pkg::panel_t  panel
);

    // Bit order {start_stop, clear, inc, prog, up, min}
    logic [5:0] pins;
    logic [5:0] sync_meta;  // First stage, may go metastable
    logic [5:0] sync_q;     // Second stage, safe to use
    logic [2:0] btn_prev;   // Buttons one cycle back for edge detect
    logic [2:0] btn_pulse;

    assign pins = {start_stop_btn, clear_btn, inc_btn, prog_sw, up_sw, min_sw};

    //////////////////////////////////////////////////
    // Two-flop synchronizer on every pin
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= pins;
            sync_q    <= sync_meta;
        end
    end

    // Rising edge of a press gives one registered pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_prev  <= '0;
            btn_pulse <= '0;
        end else begin
            btn_prev  <= sync_q[5:3];
            btn_pulse <= sync_q[5:3] & ~btn_prev;
        end
    end

    assign panel.start_stop = btn_pulse[2];
    assign panel.clear      = btn_pulse[1];
    assign panel.inc        = btn_pulse[0];
    assign panel.prog_sw    = sync_q[2];   // Switches stay levels
    assign panel.up_sw      = sync_q[1];
    assign panel.min_sw     = sync_q[0];

endmodule

/* design/stopwatch_top.sv */
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int TICKS_PER_CS = 100000   // Clock cycles per centisecond
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_stop_btn,
    input  logic                  clear_btn,
    input  logic                  inc_btn,
    input  logic                  prog_sw,
    input  logic                  up_sw,
    input  logic                  min_sw,
    output stopwatch_pkg::time_t  time_value,
    output logic                  zero_hit
);

    stopwatch_pkg::panel_t     panel;
    stopwatch_pkg::sw_state_t  state;      // Visible for debug only
    stopwatch_pkg::count_cmd_t count_cmd;
    stopwatch_pkg::prog_cmd_t  prog_cmd;
    stopwatch_pkg::time_t      preset;
    logic                      cs_tick;
    logic                      at_zero;

    //////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////
    input_sync u_input_sync (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_stop_btn (start_stop_btn),
        .clear_btn      (clear_btn),
        .inc_btn        (inc_btn),
        .prog_sw        (prog_sw),
        .up_sw          (up_sw),
        .min_sw         (min_sw),
        .panel          (panel)
    );

    mode_fsm u_mode_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .panel     (panel),
        .at_zero   (at_zero),
        .state     (state),
        .count_cmd (count_cmd),
        .prog_cmd  (prog_cmd)
    );

    preset_store u_preset_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .prog_cmd (prog_cmd),
        .preset   (preset)
    );

    // Centisecond enable beside the pipeline
    cs_tick_gen #(
        .TICKS_PER_CS (TICKS_PER_CS)
    ) u_cs_tick_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .cs_tick (cs_tick)
    );

    time_counter u_time_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .cs_tick    (cs_tick),
        .count_cmd  (count_cmd),
        .preset     (preset),
        .time_value (time_value),
        .at_zero    (at_zero),
        .zero_hit   (zero_hit)
    );

endmodule

/* design/time_counter.sv */
`timescale 1ns/1ps

module time_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cs_tick,
    input  stopwatch_pkg::count_cmd_t  count_cmd,
    input  stopwatch_pkg::time_t       preset,
    output stopwatch_pkg::time_t       time_value,
    output logic                       at_zero,
    output logic                       zero_hit
);

    logic step_en;
    logic at_max;
    logic last_step;  // Next down step ends on zero

    assign step_en   = cs_tick && count_cmd.run && !count_cmd.hold_zero;
    assign at_max    = (time_value >= stopwatch_pkg::MAX_TIME);
    assign last_step = (time_value <= stopwatch_pkg::time_t'(1));

    //////////////////////////////////////////////////
    // Centisecond count
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            time_value <= '0;
        end else if (count_cmd.clear) begin
            time_value <= '0;
        end else if (count_cmd.load) begin
            time_value <= preset;
        end else if (count_cmd.hold_zero) begin
            time_value <= '0;                      // Parked after expiry
        end else if (step_en) begin
            if (count_cmd.dir_up) begin
                if (!at_max) begin
                    time_value <= time_value + 1'b1;
                end
            end else if (!at_zero) begin
                if (last_step) begin
                    time_value <= '0;
                end else begin
                    time_value <= time_value - 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Zero detection
    //////////////////////////////////////////////////

    // at_zero marks a finished countdown until the next clear or load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            at_zero  <= 1'b0;
            zero_hit <= 1'b0;
        end else begin
            zero_hit <= 1'b0;                      // Single cycle by default
            if (count_cmd.clear || count_cmd.load) begin
                at_zero <= 1'b0;
            end else if (step_en && !count_cmd.dir_up && !at_zero && last_step) begin
                at_zero  <= 1'b1;
                zero_hit <= 1'b1;                  // Sounder pulse
            end
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the stopwatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module stopwatch_tb -Mdir obj_dir -o stopwatch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/stopwatch_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* sim.f */
+incdir+testbench
common/stopwatch_pkg.sv
design/input_sync.sv
design/cs_tick_gen.sv
control/mode_fsm.sv
control/preset_store.sv
design/time_counter.sv
design/stopwatch_top.sv
testbench/stopwatch_tb.sv

/* testbench/stopwatch_tb_table.svh */
`ifndef STOPWATCH_TB_TABLE_SVH
`define STOPWATCH_TB_TABLE_SVH

// Columns: action, switches {prog, up, min}, button, amount, relation, value, zero pulse
// Amount counts presses for ACT_PRESS and centiseconds for ACT_TICKS, 0 means a random hold

typedef enum logic [1:0] {
    ACT_SET,    // Apply switches and let them settle
    ACT_PRESS,  // Press a button amount times
    ACT_TICKS,  // Wait a number of centiseconds
    ACT_ZERO    // Wait for the zero pulse
} action_t;

typedef enum logic [1:0] {BTN_NONE, BTN_START, BTN_CLEAR, BTN_INC} button_t;

typedef enum logic [2:0] {
    REL_ANY,   // No time check
    REL_EQ,    // Equal to value
    REL_GT,    // Greater than value
    REL_UP,    // Greater than the previous step
    REL_DOWN,  // Less than the previous step
    REL_SAME   // Unchanged since the previous step
} rel_t;

typedef struct packed {
    action_t              action;
    logic [2:0]           sw;        // {prog, up, min}
    button_t              button;
    logic [7:0]           amount;
    rel_t                 rel;
    stopwatch_pkg::time_t value;
    logic                 zero_exp;  // Zero pulse seen during the step
} step_t;

localparam int NUM_STEPS = 30;

step_t steps [NUM_STEPS];

task automatic fill_steps();
    // Reset, count up with pause, clear
    steps[0]  = '{ACT_SET,   3'b010, BTN_NONE,  8'd0,  REL_EQ,   19'd0,      1'b0};
    steps[1]  = '{ACT_PRESS, 3'b010, BTN_START, 8'd1,  REL_ANY,  19'd0,      1'b0};
    steps[2]  = '{ACT_TICKS, 3'b010, BTN_NONE,  8'd5,  REL_UP,   19'd0,      1'b0};
    steps[3]  = '{ACT_PRESS, 3'b010, BTN_START, 8'd1,  REL_ANY,  19'd0,      1'b0};
    steps[4]  = '{ACT_TICKS, 3'b010, BTN_NONE,  8'd0,  REL_SAME, 19'd0,      1'b0};
    steps[5]  = '{ACT_PRESS, 3'b010, BTN_START, 8'd1,  REL_ANY,  19'd0,      1'b0};
    steps[6]  = '{ACT_TICKS, 3'b010, BTN_NONE,  8'd5,  REL_UP,   19'd0,      1'b0};
    steps[7]  = '{ACT_PRESS, 3'b010, BTN_CLEAR, 8'd1,  REL_EQ,   19'd0,      1'b0};
    // Program 2 minutes and 3 seconds
    steps[8]  = '{ACT_SET,   3'b101, BTN_NONE,  8'd0,  REL_EQ,   19'd0,      1'b0};
    steps[9]  = '{ACT_PRESS, 3'b101, BTN_INC,   8'd2,  REL_EQ,   19'd12000,  1'b0};
    steps[10] = '{ACT_SET,   3'b100, BTN_NONE,  8'd0,  REL_EQ,   19'd12000,  1'b0};
    steps[11] = '{ACT_PRESS, 3'b100, BTN_INC,   8'd3,  REL_EQ,   19'd12300,  1'b0};
    steps[12] = '{ACT_SET,   3'b000, BTN_NONE,  8'd0,  REL_EQ,   19'd12300,  1'b0};
    // Countdown, then pause at a nonzero value
    steps[13] = '{ACT_PRESS, 3'b000, BTN_START, 8'd1,  REL_DOWN, 19'd0,      1'b0};
    steps[14] = '{ACT_TICKS, 3'b000, BTN_NONE,  8'd5,  REL_DOWN, 19'd0,      1'b0};
    steps[15] = '{ACT_PRESS, 3'b000, BTN_START, 8'd1,  REL_GT,   19'd0,      1'b0};
    steps[16] = '{ACT_TICKS, 3'b000, BTN_NONE,  8'd0,  REL_SAME, 19'd0,      1'b0};
    // Saturation at 59:59.99
    steps[17] = '{ACT_SET,   3'b101, BTN_NONE,  8'd0,  REL_EQ,   19'd12300,  1'b0};
    steps[18] = '{ACT_PRESS, 3'b101, BTN_CLEAR, 8'd1,  REL_EQ,   19'd0,      1'b0};
    steps[19] = '{ACT_PRESS, 3'b101, BTN_INC,   8'd61, REL_EQ,   19'd359999, 1'b0};
    // One second countdown to zero
    steps[20] = '{ACT_PRESS, 3'b101, BTN_CLEAR, 8'd1,  REL_EQ,   19'd0,      1'b0};
    steps[21] = '{ACT_SET,   3'b100, BTN_NONE,  8'd0,  REL_EQ,   19'd0,      1'b0};
    steps[22] = '{ACT_PRESS, 3'b100, BTN_INC,   8'd1,  REL_EQ,   19'd100,    1'b0};
    steps[23] = '{ACT_SET,   3'b000, BTN_NONE,  8'd0,  REL_EQ,   19'd100,    1'b0};
    steps[24] = '{ACT_PRESS, 3'b000, BTN_START, 8'd1,  REL_DOWN, 19'd0,      1'b0};
    steps[25] = '{ACT_TICKS, 3'b000, BTN_NONE,  8'd80, REL_DOWN, 19'd0,      1'b0};
    steps[26] = '{ACT_ZERO,  3'b000, BTN_NONE,  8'd0,  REL_EQ,   19'd0,      1'b1};
    steps[27] = '{ACT_TICKS, 3'b000, BTN_NONE,  8'd10, REL_EQ,   19'd0,      1'b0};
    steps[28] = '{ACT_PRESS, 3'b000, BTN_START, 8'd1,  REL_EQ,   19'd0,      1'b0};
    steps[29] = '{ACT_SET,   3'b010, BTN_NONE,  8'd0,  REL_EQ,   19'd0,      1'b0};
endtask

`endif

/* testbench/stopwatch_tb.sv */
`timescale 1ns/1ps

module stopwatch_tb;

    localparam int TICKS_PER_CS   = 4;
    localparam int TIMEOUT_CYCLES = 50 * TICKS_PER_CS;
    localparam int PRESS_CYCLES   = 2;
    localparam int SETTLE_CYCLES  = 8;  // Edge to stable display is at most 6 cycles

    logic                     clk;
    logic                     rst_n;
    logic                     start_stop_btn;
    logic                     clear_btn;
    logic                     inc_btn;
    logic                     prog_sw;
    logic                     up_sw;
    logic                     min_sw;
    stopwatch_pkg::time_t     time_value;
    logic                     zero_hit;
    logic                     zero_seen;   // Zero pulse observed in the current step
    stopwatch_pkg::time_t     last_time;   // Display at the end of the previous step
    stopwatch_pkg::sw_state_t cur_state;

    `include "stopwatch_tb_table.svh"

    stopwatch_top #(
        .TICKS_PER_CS (TICKS_PER_CS)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_stop_btn (start_stop_btn),
        .clear_btn      (clear_btn),
        .inc_btn        (inc_btn),
        .prog_sw        (prog_sw),
        .up_sw          (up_sw),
        .min_sw         (min_sw),
        .time_value     (time_value),
        .zero_hit       (zero_hit)
    );

    assign cur_state = dut0.state;  // For messages only

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Cycle stepping and stimulus
    //////////////////////////////////////////////////

    // Lands 1 ns after the rising edge where inputs change and outputs are read
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (zero_hit === 1'b1) begin
            zero_seen = 1'b1;
        end
    endtask

    task automatic drive_button(input button_t btn, input logic level);
        case (btn)
            BTN_START: start_stop_btn = level;
            BTN_CLEAR: clear_btn = level;
            BTN_INC:   inc_btn = level;
            default: ;
        endcase
    endtask

    task automatic settle();
        for (int c = 0; c < SETTLE_CYCLES; c++) begin
            next_cycle();
        end
    endtask

    task automatic press_button(input button_t btn);
        drive_button(btn, 1'b1);
        for (int c = 0; c < PRESS_CYCLES; c++) begin
            next_cycle();
        end
        drive_button(btn, 1'b0);
        settle();
    endtask

    task automatic wait_centisec(input logic [7:0] amount);
        int cs_count;
        if (amount == 8'd0) begin
            cs_count = 2 + int'($urandom % 19);  // Random hold of 2 to 20
        end else begin
            cs_count = int'(amount);
        end
        for (int c = 0; c < cs_count * TICKS_PER_CS; c++) begin
            next_cycle();
        end
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_time(input stopwatch_pkg::time_t actual, input rel_t rel,
                              input stopwatch_pkg::time_t ref_value, input string what);
        logic ok;
        case (rel)
            REL_EQ, REL_SAME: ok = (actual == ref_value);
            REL_GT, REL_UP:   ok = (actual > ref_value);
            REL_DOWN:         ok = (actual < ref_value);
            default:          ok = 1'b1;
        endcase
        if ($isunknown(actual)) begin
            ok = 1'b0;
        end
        if (!ok) begin
            $display("[FAIL] %0t: %s, time_value %0d, expected %s %0d",
                     $time, what, actual, rel.name(), ref_value);
            $display("TB FAILED");
            $fatal(1, "time_value check failed");
        end
    endtask

    task automatic check_zero(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, zero pulse seen %b, expected %b",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "zero_hit check failed");
        end
    endtask

    task automatic wait_for_zero_hit(input string what);
        int cycles;
        cycles = 0;
        while (zero_hit !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (zero_hit !== 1'b1) begin
            $display("Timeout at %0t: %s, countdown gave no zero pulse in %0d cycles",
                     $time, what, TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
        zero_seen = 1'b1;
        check_time(time_value, REL_EQ, '0, {what, ", during zero pulse"});
    endtask

    //////////////////////////////////////////////////
    // Table driver
    //////////////////////////////////////////////////
    task automatic run_step(input int idx);
        step_t                s;
        stopwatch_pkg::time_t ref_value;
        string                what;
        s = steps[idx];
        zero_seen = 1'b0;
        {prog_sw, up_sw, min_sw} = s.sw;
        what = $sformatf("step %0d, state %s", idx, cur_state.name());
        case (s.action)
            ACT_SET:   settle();
            ACT_PRESS: begin
                for (int n = 0; n < int'(s.amount); n++) begin
                    press_button(s.button);
                end
            end
            ACT_TICKS: wait_centisec(s.amount);
            default:   wait_for_zero_hit(what);
        endcase
        case (s.rel)
            REL_UP, REL_DOWN, REL_SAME: ref_value = last_time;  // Relative to previous step
            default:                    ref_value = s.value;
        endcase
        what = $sformatf("step %0d, state %s", idx, cur_state.name());
        check_time(time_value, s.rel, ref_value, what);
        check_zero(zero_seen, s.zero_exp, what);
        last_time = time_value;
    endtask

    initial begin
        rst_n          = 1'b0;
        start_stop_btn = 1'b0;
        clear_btn      = 1'b0;
        inc_btn        = 1'b0;
        prog_sw        = 1'b0;
        up_sw          = 1'b1;
        min_sw         = 1'b0;
        zero_seen      = 1'b0;
        last_time      = '0;
        void'($urandom(71));
        fill_steps();
        next_cycle();
        next_cycle();
        rst_n = 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(i);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
